/* design/cache_cfg_pkg.sv */
package cache_cfg_pkg;

    localparam int num_ways       = 2;
    localparam int num_sets       = 16;
    localparam int words_per_line = 4;
    localparam int tag_w          = 24;
    localparam int index_w        = 4;
    localparam int word_sel_w     = 2;

    // byte address split as tag | index | word | byte
    typedef logic [31:0]           addr_t;
    typedef logic [tag_w-1:0]      tag_t;
    typedef logic [index_w-1:0]    index_t;
    typedef logic [word_sel_w-1:0] word_sel_t;
    typedef logic                  way_t;
    typedef logic [31:0]           word_t;
    typedef logic [3:0]            wmask_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        evict,
        refill,
        replay
    } ctrl_state_t;

endpackage

/* design/mem_bus_pkg.sv */
package mem_bus_pkg;

    // byte address >> 4
    typedef logic [27:0]  line_addr_t;
    typedef logic [31:0]  beat_t;

    // word 0 sits in bits 31:0
    typedef logic [127:0] line_t;

    typedef logic [1:0]   beat_cnt_t;

    localparam beat_cnt_t last_beat = 2'd3;

endpackage

/* design/dcache_way.sv */
module dcache_way (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_cfg_pkg::index_t rd_index,
    output cache_cfg_pkg::tag_t   tag,
    output logic                  valid,
    output logic                  dirty,
    output mem_bus_pkg::line_t    line,
    input  logic                  wr_en,
    input  cache_cfg_pkg::index_t wr_index,
    input  mem_bus_pkg::line_t    wr_line,
    input  logic [15:0]           wr_byte_en,
    input  cache_cfg_pkg::tag_t   wr_tag,
    input  logic                  set_valid,
    input  logic                  set_dirty
);

    cache_cfg_pkg::tag_t tag_mem [cache_cfg_pkg::num_sets];
    mem_bus_pkg::line_t line_mem [cache_cfg_pkg::num_sets];
    logic [cache_cfg_pkg::num_sets-1:0] valid_q;
    logic [cache_cfg_pkg::num_sets-1:0] dirty_q;

    // refill writes clean, store hit writes dirty
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            valid   <= 1'b0;
            dirty   <= 1'b0;
        end else begin
            valid <= valid_q[rd_index];
            dirty <= dirty_q[rd_index];
            if (wr_en) begin
                dirty_q[wr_index] <= set_dirty;
                if (set_valid) begin
                    valid_q[wr_index] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && set_valid) begin
            tag_mem[wr_index] <= wr_tag;
        end
        for (int b = 0; b < 16; b++) begin
            if (wr_en && wr_byte_en[b]) begin
                line_mem[wr_index][b*8 +: 8] <= wr_line[b*8 +: 8];
            end
        end
        tag  <= tag_mem[rd_index];
        line <= line_mem[rd_index];
    end

endmodule

/* design/dcache_lru.sv */
module dcache_lru (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   touch,
    input  cache_cfg_pkg::index_t                  touch_index,
    input  cache_cfg_pkg::way_t                    touch_way,
    input  cache_cfg_pkg::index_t                  rd_index,
    input  logic [cache_cfg_pkg::num_ways-1:0]     valid,
    output cache_cfg_pkg::way_t                    victim
);

    // each bit names the way to replace next
    logic [cache_cfg_pkg::num_sets-1:0] lru_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q <= '0;
        end else if (touch) begin
            lru_q[touch_index] <= ~touch_way;
        end
    end

    // empty ways first, way 0 before way 1
    always_comb begin
        if (!valid[0]) begin
            victim = 1'b0;
        end else if (!valid[1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[rd_index];
        end
    end

endmodule

/* design/dcache_refill.sv */
module dcache_refill (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  mem_bus_pkg::line_addr_t line_addr,
    output logic                    mem_rd_req,
    output mem_bus_pkg::line_addr_t mem_rd_addr,
    input  logic                    mem_rd_valid,
    input  mem_bus_pkg::beat_t      mem_rd_data,
    output logic                    line_done,
    output mem_bus_pkg::line_t      line
);

    mem_bus_pkg::beat_cnt_t cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_rd_req <= 1'b0;
            line_done  <= 1'b0;
            cnt        <= '0;
        end else begin
            mem_rd_req <= start;
            line_done  <= mem_rd_valid && (cnt == mem_bus_pkg::last_beat);
            if (start) begin
                cnt <= '0;
            end else if (mem_rd_valid) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // beats arrive in word order
    always_ff @(posedge clk) begin
        if (start) begin
            mem_rd_addr <= line_addr;
        end
        for (int w = 0; w < cache_cfg_pkg::words_per_line; w++) begin
            if (mem_rd_valid && (cnt == mem_bus_pkg::beat_cnt_t'(w))) begin
                line[w*32 +: 32] <= mem_rd_data;
            end
        end
    end

endmodule

/* design/dcache_evict.sv */
module dcache_evict (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  mem_bus_pkg::line_t      victim_line,
    input  mem_bus_pkg::line_addr_t victim_addr,
    output logic                    mem_wr_valid,
    output cache_cfg_pkg::addr_t    mem_wr_addr,
    output mem_bus_pkg::beat_t      mem_wr_data,
    output logic                    done
);

    mem_bus_pkg::line_t      line_q;
    mem_bus_pkg::line_addr_t addr_q;
    mem_bus_pkg::beat_cnt_t  cnt;
    logic                    active;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (start) begin
            active <= 1'b1;
            cnt    <= '0;
        end else if (active) begin
            cnt <= cnt + 1'b1;
            if (cnt == mem_bus_pkg::last_beat) begin
                active <= 1'b0;
            end
        end
    end

    // victim snapshot, the way may be refilled behind us
    always_ff @(posedge clk) begin
        if (start) begin
            line_q <= victim_line;
            addr_q <= victim_addr;
        end
    end

    assign mem_wr_valid = active;
    assign mem_wr_addr  = {addr_q, cnt, 2'b00};
    assign mem_wr_data  = line_q[cnt*32 +: 32];
    assign done         = active && (cnt == mem_bus_pkg::last_beat);

endmodule

/* design/dcache_ctrl.sv */
module dcache_ctrl (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          ld_req,
    input  cache_cfg_pkg::addr_t                          ld_addr,
    output logic                                          ld_ready,
    output logic                                          ld_valid,
    output cache_cfg_pkg::word_t                          ld_data,
    input  logic                                          st_req,
    input  cache_cfg_pkg::addr_t                          st_addr,
    input  cache_cfg_pkg::word_t                          st_data,
    input  cache_cfg_pkg::wmask_t                         st_mask,
    output logic                                          st_ready,
    output logic                                          st_done,
    output cache_cfg_pkg::index_t                         rd_index,
    input  cache_cfg_pkg::tag_t [cache_cfg_pkg::num_ways-1:0] way_tag,
    input  logic [cache_cfg_pkg::num_ways-1:0]            way_valid,
    input  logic [cache_cfg_pkg::num_ways-1:0]            way_dirty,
    input  mem_bus_pkg::line_t [cache_cfg_pkg::num_ways-1:0]  way_line,
    output logic [cache_cfg_pkg::num_ways-1:0]            wr_en,
    output cache_cfg_pkg::index_t                         wr_index,
    output mem_bus_pkg::line_t                            wr_line,
    output logic [15:0]                                   wr_word_mask,
    output cache_cfg_pkg::tag_t                           wr_tag,
    output logic                                          set_valid,
    output logic                                          set_dirty,
    output logic                                          lru_touch,
    output cache_cfg_pkg::way_t                           lru_way,
    input  cache_cfg_pkg::way_t                           victim,
    output logic                                          refill_start,
    output mem_bus_pkg::line_addr_t                       refill_addr,
    input  logic                                          refill_done,
    input  mem_bus_pkg::line_t                            refill_line,
    output logic                                          evict_start,
    output mem_bus_pkg::line_t                            evict_line,
    output mem_bus_pkg::line_addr_t                       evict_addr,
    input  logic                                          evict_done
);

    cache_cfg_pkg::ctrl_state_t state;
    logic                       req_st;
    cache_cfg_pkg::addr_t       req_addr;
    cache_cfg_pkg::word_t       req_data;
    cache_cfg_pkg::wmask_t      req_mask;
    cache_cfg_pkg::way_t        victim_q;
    cache_cfg_pkg::tag_t        req_tag;
    cache_cfg_pkg::index_t      req_index;
    cache_cfg_pkg::word_sel_t   req_word;
    logic [cache_cfg_pkg::num_ways-1:0] hit_vec;
    logic                       hit;
    cache_cfg_pkg::way_t        hit_way;
    mem_bus_pkg::line_t         hit_line;
    logic                       ld_acc;
    logic                       st_acc;
    logic                       in_lookup;
    logic                       victim_dirty;

    assign req_tag   = req_addr[31:8];
    assign req_index = req_addr[7:4];
    assign req_word  = req_addr[3:2];

    // loads win; hold off while a response is out
    assign ld_ready = (state == cache_cfg_pkg::idle) && !ld_valid && !st_done;
    assign st_ready = ld_ready && !ld_req;
    assign ld_acc   = ld_req && ld_ready;
    assign st_acc   = st_req && st_ready;

    // arrays see the incoming address while idle
    assign rd_index = (state != cache_cfg_pkg::idle) ? req_index :
                      ld_req ? ld_addr[7:4] : st_addr[7:4];

    always_comb begin
        for (int w = 0; w < cache_cfg_pkg::num_ways; w++) begin
            hit_vec[w] = way_valid[w] && (way_tag[w] == req_tag);
        end
    end

    assign in_lookup    = state == cache_cfg_pkg::lookup;
    assign hit          = |hit_vec;
    assign hit_way      = hit_vec[1];
    assign hit_line     = way_line[hit_way];
    assign victim_dirty = way_valid[victim] && way_dirty[victim];

    always_comb begin
        wr_en        = '0;
        wr_line      = {cache_cfg_pkg::words_per_line{req_data}};
        wr_word_mask = {12'b0, req_mask} << (4 * req_word);
        set_valid    = 1'b0;
        set_dirty    = 1'b1;
        lru_touch    = 1'b0;
        lru_way      = hit_way;
        if (in_lookup && hit) begin
            wr_en[hit_way] = req_st;
            lru_touch      = 1'b1;
        end else if (state == cache_cfg_pkg::refill && refill_done) begin
            // fresh line lands clean
            wr_en[victim_q] = 1'b1;
            wr_line         = refill_line;
            wr_word_mask    = '1;
            set_valid       = 1'b1;
            set_dirty       = 1'b0;
            lru_touch       = 1'b1;
            lru_way         = victim_q;
        end
    end

    assign wr_index = req_index;
    assign wr_tag   = req_tag;

    assign evict_start  = in_lookup && !hit && victim_dirty;
    assign evict_line   = way_line[victim];
    assign evict_addr   = {way_tag[victim], req_index};
    assign refill_start = (in_lookup && !hit && !victim_dirty) ||
                          (state == cache_cfg_pkg::evict && evict_done);
    assign refill_addr  = {req_tag, req_index};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= cache_cfg_pkg::idle;
            ld_valid <= 1'b0;
            st_done  <= 1'b0;
        end else begin
            ld_valid <= in_lookup && hit && !req_st;
            st_done  <= in_lookup && hit && req_st;
            case (state)
                cache_cfg_pkg::idle: begin
                    if (ld_acc || st_acc) begin
                        state <= cache_cfg_pkg::lookup;
                    end
                end
                cache_cfg_pkg::lookup: begin
                    if (hit) begin
                        state <= cache_cfg_pkg::idle;
                    end else if (victim_dirty) begin
                        state <= cache_cfg_pkg::evict;
                    end else begin
                        state <= cache_cfg_pkg::refill;
                    end
                end
                cache_cfg_pkg::evict: begin
                    if (evict_done) begin
                        state <= cache_cfg_pkg::refill;
                    end
                end
                cache_cfg_pkg::refill: begin
                    if (refill_done) begin
                        state <= cache_cfg_pkg::replay;
                    end
                end
                // one cycle for the arrays to show the new line
                cache_cfg_pkg::replay: state <= cache_cfg_pkg::lookup;
                default: state <= cache_cfg_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ld_acc || st_acc) begin
            req_st   <= !ld_acc;
            req_addr <= ld_acc ? ld_addr : st_addr;
            req_data <= st_data;
            req_mask <= st_mask;
        end
        if (in_lookup && !hit) begin
            victim_q <= victim;
        end
        if (in_lookup) begin
            ld_data <= hit_line[req_word*32 +: 32];
        end
    end

endmodule

/* design/dcache_top.sv */
module dcache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ld_req,
    input  cache_cfg_pkg::addr_t    ld_addr,
    output logic                    ld_ready,
    output logic                    ld_valid,
    output cache_cfg_pkg::word_t    ld_data,
    input  logic                    st_req,
    input  cache_cfg_pkg::addr_t    st_addr,
    input  cache_cfg_pkg::word_t    st_data,
    input  cache_cfg_pkg::wmask_t   st_mask,
    output logic                    st_ready,
    output logic                    st_done,
    output logic                    mem_rd_req,
    output mem_bus_pkg::line_addr_t mem_rd_addr,
    input  logic                    mem_rd_valid,
    input  mem_bus_pkg::beat_t      mem_rd_data,
    output logic                    mem_wr_valid,
    output cache_cfg_pkg::addr_t    mem_wr_addr,
    output mem_bus_pkg::beat_t      mem_wr_data
);

    cache_cfg_pkg::index_t                                rd_index;
    cache_cfg_pkg::tag_t [cache_cfg_pkg::num_ways-1:0]    way_tag;
    logic [cache_cfg_pkg::num_ways-1:0]                   way_valid;
    logic [cache_cfg_pkg::num_ways-1:0]                   way_dirty;
    mem_bus_pkg::line_t [cache_cfg_pkg::num_ways-1:0]     way_line;
    logic [cache_cfg_pkg::num_ways-1:0]                   wr_en;
    cache_cfg_pkg::index_t                                wr_index;
    mem_bus_pkg::line_t                                   wr_line;
    logic [15:0]                                          wr_word_mask;
    cache_cfg_pkg::tag_t                                  wr_tag;
    logic                                                 set_valid;
    logic                                                 set_dirty;
    logic                                                 lru_touch;
    cache_cfg_pkg::way_t                                  lru_way;
    cache_cfg_pkg::way_t                                  victim;
    logic                                                 refill_start;
    mem_bus_pkg::line_addr_t                              refill_addr;
    logic                                                 refill_done;
    mem_bus_pkg::line_t                                   refill_line;
    logic                                                 evict_start;
    mem_bus_pkg::line_t                                   evict_line;
    mem_bus_pkg::line_addr_t                              evict_addr;
    logic                                                 evict_done;

    dcache_ctrl ctrl (
        .clk, .rst,
        .ld_req, .ld_addr, .ld_ready, .ld_valid, .ld_data,
        .st_req, .st_addr, .st_data, .st_mask, .st_ready, .st_done,
        .rd_index, .way_tag, .way_valid, .way_dirty, .way_line,
        .wr_en, .wr_index, .wr_line, .wr_word_mask, .wr_tag, .set_valid, .set_dirty,
        .lru_touch, .lru_way, .victim,
        .refill_start, .refill_addr, .refill_done, .refill_line,
        .evict_start, .evict_line, .evict_addr, .evict_done
    );

    dcache_way way0 (
        .clk, .rst, .rd_index,
        .tag(way_tag[0]), .valid(way_valid[0]), .dirty(way_dirty[0]), .line(way_line[0]),
        .wr_en(wr_en[0]), .wr_index, .wr_line, .wr_byte_en(wr_word_mask), .wr_tag,
        .set_valid, .set_dirty
    );

    dcache_way way1 (
        .clk, .rst, .rd_index,
        .tag(way_tag[1]), .valid(way_valid[1]), .dirty(way_dirty[1]), .line(way_line[1]),
        .wr_en(wr_en[1]), .wr_index, .wr_line, .wr_byte_en(wr_word_mask), .wr_tag,
        .set_valid, .set_dirty
    );

    // touch index is the request set, same as the write index
    dcache_lru lru (
        .clk, .rst, .touch(lru_touch), .touch_index(wr_index), .touch_way(lru_way),
        .rd_index, .valid(way_valid), .victim
    );

    dcache_refill refill (
        .clk, .rst, .start(refill_start), .line_addr(refill_addr),
        .mem_rd_req, .mem_rd_addr, .mem_rd_valid, .mem_rd_data,
        .line_done(refill_done), .line(refill_line)
    );

    dcache_evict evict (
        .clk, .rst, .start(evict_start), .victim_line(evict_line), .victim_addr(evict_addr),
        .mem_wr_valid, .mem_wr_addr, .mem_wr_data, .done(evict_done)
    );

endmodule

/* dv/clk_gen.sv */
module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for 4 rising edges, dropped on a falling edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* dv/mem_model.sv */
module mem_model (
    input  logic                    clk,
    input  logic                    mem_rd_req,
    input  mem_bus_pkg::line_addr_t mem_rd_addr,
    output logic                    mem_rd_valid,
    output mem_bus_pkg::beat_t      mem_rd_data,
    input  logic                    mem_wr_valid,
    input  cache_cfg_pkg::addr_t    mem_wr_addr,
    input  mem_bus_pkg::beat_t      mem_wr_data
);

    // 4 KiB window, word index is byte address bits 11:2
    mem_bus_pkg::beat_t mem [1024];
    integer             seed;
    logic [7:0]         base;
    int                 beat;
    int                 gap;
    logic               busy;

    initial begin
        seed = 32'hed4f_32e0;
        for (int i = 0; i < 1024; i++) begin
            mem[10'(i)] = 32'(i << 2) ^ 32'h5a5a_0000;
        end
        mem_rd_valid = 1'b0;
        mem_rd_data  = '0;
        busy         = 1'b0;
        beat         = 0;
        gap          = 0;
        base         = '0;
        forever begin
            @(negedge clk);
            mem_rd_valid = 1'b0;
            if (mem_wr_valid) begin
                mem[mem_wr_addr[11:2]] = mem_wr_data;
            end
            if (mem_rd_req) begin
                base = mem_rd_addr[7:0];
                beat = 0;
                gap  = 1 + ($unsigned($random(seed)) % 3);
                busy = 1'b1;
            end else if (busy) begin
                gap--;
                if (gap == 0) begin
                    // beats in word order, sometimes with a hole between them
                    mem_rd_valid = 1'b1;
                    mem_rd_data  = mem[{base, 2'(beat)}];
                    beat++;
                    busy = beat < 4;
                    gap  = 1 + ($unsigned($random(seed)) % 2);
                end
            end
        end
    end

endmodule

/* dv/dcache_props.sv */
module dcache_props (
    input logic clk,
    input logic rst,
    input logic ld_req,
    input logic ld_ready,
    input logic ld_valid,
    input logic st_req,
    input logic st_ready,
    input logic st_done,
    input logic mem_rd_req,
    input logic mem_wr_valid
);

    int   fail_cnt = 0;
    logic accept;

    assign accept = (ld_req && ld_ready) || (st_req && st_ready);

    resp_exclusive: assert property (@(posedge clk) disable iff (rst) !(ld_valid && st_done))
        else begin
            $error("ld_valid and st_done high in the same cycle");
            fail_cnt++;
        end

    mem_dir_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd_req && mem_wr_valid))
        else begin
            $error("mem_rd_req high during a write beat");
            fail_cnt++;
        end

    // one request at a time
    ready_drops: assert property (@(posedge clk) disable iff (rst)
        accept |=> (!ld_ready && !st_ready))
        else begin
            $error("ready still high the cycle after an accept");
            fail_cnt++;
        end

endmodule

bind dcache_top dcache_props props (
    .clk, .rst, .ld_req, .ld_ready, .ld_valid, .st_req, .st_ready, .st_done,
    .mem_rd_req, .mem_wr_valid
);

/* dv/dcache_tb.sv */
module dcache_tb;

    localparam int num_tests      = 5;
    localparam int miss_budget    = 800;
    localparam int timeout_cycles = num_tests * miss_budget;

    logic                    clk;
    logic                    rst;
    logic                    ld_req;
    cache_cfg_pkg::addr_t    ld_addr;
    logic                    ld_ready;
    logic                    ld_valid;
    cache_cfg_pkg::word_t    ld_data;
    logic                    st_req;
    cache_cfg_pkg::addr_t    st_addr;
    cache_cfg_pkg::word_t    st_data;
    cache_cfg_pkg::wmask_t   st_mask;
    logic                    st_ready;
    logic                    st_done;
    logic                    mem_rd_req;
    mem_bus_pkg::line_addr_t mem_rd_addr;
    logic                    mem_rd_valid;
    mem_bus_pkg::beat_t      mem_rd_data;
    logic                    mem_wr_valid;
    cache_cfg_pkg::addr_t    mem_wr_addr;
    mem_bus_pkg::beat_t      mem_wr_data;

    cache_cfg_pkg::word_t    shadow [1024];
    int                      errors = 0;
    int                      cycles = 0;
    int                      rd_req_cnt = 0;
    mem_bus_pkg::line_addr_t last_rd_addr;
    cache_cfg_pkg::addr_t    wr_addr_q [$];
    cache_cfg_pkg::word_t    wr_data_q [$];
    integer                  seed;

    clk_gen clk_gen_i (.clk, .rst);

    mem_model mem (
        .clk, .mem_rd_req, .mem_rd_addr, .mem_rd_valid, .mem_rd_data,
        .mem_wr_valid, .mem_wr_addr, .mem_wr_data
    );

    dcache_top UUT (
        .clk, .rst,
        .ld_req, .ld_addr, .ld_ready, .ld_valid, .ld_data,
        .st_req, .st_addr, .st_data, .st_mask, .st_ready, .st_done,
        .mem_rd_req, .mem_rd_addr, .mem_rd_valid, .mem_rd_data,
        .mem_wr_valid, .mem_wr_addr, .mem_wr_data
    );

    // memory side traffic, sampled mid-cycle
    always @(negedge clk) begin
        if (mem_rd_req) begin
            rd_req_cnt++;
            last_rd_addr = mem_rd_addr;
        end
        if (mem_wr_valid) begin
            wr_addr_q.push_back(mem_wr_addr);
            wr_data_q.push_back(mem_wr_data);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("run stopped after %0d cycles without finishing the tests", cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input cache_cfg_pkg::word_t got,
                              input cache_cfg_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input cache_cfg_pkg::addr_t got,
                              input cache_cfg_pkg::addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_int(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("%s was %0d, expected %0d", what, got, exp);
        end
    endtask

    task automatic apply_store(input cache_cfg_pkg::addr_t a, input cache_cfg_pkg::word_t d,
                               input cache_cfg_pkg::wmask_t m);
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                shadow[a[11:2]][b*8 +: 8] = d[b*8 +: 8];
            end
        end
    endtask

    // lat counts edges from the accepting edge to the one that shows ld_valid
    task automatic load_op(input cache_cfg_pkg::addr_t a, output int lat);
        cache_cfg_pkg::word_t exp;
        @(negedge clk);
        while (!ld_ready) @(negedge clk);
        ld_req  = 1'b1;
        ld_addr = a;
        exp     = shadow[a[11:2]];
        @(posedge clk);
        @(negedge clk);
        ld_req = 1'b0;
        lat    = 1;
        while (!ld_valid) begin
            @(negedge clk);
            lat++;
        end
        check_word("ld_data", ld_data, exp);
    endtask

    task automatic store_op(input cache_cfg_pkg::addr_t a, input cache_cfg_pkg::word_t d,
                            input cache_cfg_pkg::wmask_t m, output int lat);
        @(negedge clk);
        while (!st_ready) @(negedge clk);
        st_req  = 1'b1;
        st_addr = a;
        st_data = d;
        st_mask = m;
        @(posedge clk);
        @(negedge clk);
        st_req = 1'b0;
        apply_store(a, d, m);
        lat = 1;
        while (!st_done) begin
            @(negedge clk);
            lat++;
        end
    endtask

    // both requests in one cycle, the load has to go first
    task automatic load_store_pair(input cache_cfg_pkg::addr_t la,
                                   input cache_cfg_pkg::addr_t sa,
                                   input cache_cfg_pkg::word_t d,
                                   input cache_cfg_pkg::wmask_t m);
        cache_cfg_pkg::word_t exp;
        @(negedge clk);
        while (!ld_ready) @(negedge clk);
        ld_req  = 1'b1;
        ld_addr = la;
        st_req  = 1'b1;
        st_addr = sa;
        st_data = d;
        st_mask = m;
        exp     = shadow[la[11:2]];
        @(posedge clk);
        @(negedge clk);
        ld_req = 1'b0;
        while (!ld_valid) begin
            if (st_done) begin
                errors++;
                $display("store finished before the load issued in the same cycle");
            end
            @(negedge clk);
        end
        check_word("ld_data", ld_data, exp);
        while (!st_ready) @(negedge clk);
        @(posedge clk);
        @(negedge clk);
        st_req = 1'b0;
        apply_store(sa, d, m);
        while (!st_done) @(negedge clk);
    endtask

    // sets 2 and 3, tags 0 to 3
    function automatic cache_cfg_pkg::addr_t rand_addr();
        logic [31:0] r;
        r = $random(seed);
        return {22'b0, r[1:0], 3'b001, r[2], r[4:3], 2'b00};
    endfunction

    task automatic cold_load_miss();
        int lat;
        int reqs;
        reqs = rd_req_cnt;
        load_op(32'h0000_0048, lat);
        check_int("read requests for a cold miss", rd_req_cnt - reqs, 1);
        check_addr("mem_rd_addr", {last_rd_addr, 4'h0}, 32'h0000_0040);
    endtask

    task automatic store_then_load();
        int lat;
        store_op(32'h0000_0044, 32'hdead_beef, 4'b0110, lat);
        check_int("store hit latency", lat, 2);
        load_op(32'h0000_0044, lat);
        check_int("load hit latency", lat, 2);
    endtask

    task automatic dirty_eviction();
        int lat;
        int first;
        cache_cfg_pkg::addr_t wa;
        store_op(32'h0000_0094, 32'h1122_3344, 4'b1001, lat);
        store_op(32'h0000_0198, 32'h5566_7788, 4'b1111, lat);
        first = wr_addr_q.size();
        store_op(32'h0000_029c, 32'h99aa_bbcc, 4'b0011, lat);
        check_int("write beats on a dirty eviction", wr_addr_q.size() - first, 4);
        if (wr_addr_q.size() - first == 4) begin
            for (int b = 0; b < 4; b++) begin
                wa = 32'h0000_0090 + 32'(4 * b);
                check_addr("mem_wr_addr", wr_addr_q[first + b], wa);
                check_word("mem_wr_data", wr_data_q[first + b], shadow[wa[11:2]]);
            end
        end
    endtask

    task automatic lru_order();
        int lat;
        int reqs;
        load_op(32'h0000_00c0, lat);
        load_op(32'h0000_01c4, lat);
        load_op(32'h0000_00c8, lat);
        reqs = rd_req_cnt;
        load_op(32'h0000_02cc, lat);
        check_int("read requests for the third line", rd_req_cnt - reqs, 1);
        check_addr("mem_rd_addr", {last_rd_addr, 4'h0}, 32'h0000_02c0);
        reqs = rd_req_cnt;
        load_op(32'h0000_00c4, lat);
        check_int("read requests for the recently used line", rd_req_cnt - reqs, 0);
        check_int("latency of the recently used line", lat, 2);
        reqs = rd_req_cnt;
        load_op(32'h0000_01c0, lat);
        check_int("read requests for the evicted line", rd_req_cnt - reqs, 1);
        check_addr("mem_rd_addr", {last_rd_addr, 4'h0}, 32'h0000_01c0);
    endtask

    task automatic random_mix();
        int lat;
        int kind;
        logic [31:0] r;
        cache_cfg_pkg::addr_t a;
        cache_cfg_pkg::word_t d;
        for (int i = 0; i < 200; i++) begin
            kind = $unsigned($random(seed)) % 8;
            a    = rand_addr();
            d    = $random(seed);
            r    = $random(seed);
            if (kind < 3) begin
                load_op(a, lat);
            end else if (kind < 6) begin
                store_op(a, d, r[3:0], lat);
            end else begin
                load_store_pair(a, rand_addr(), d, r[3:0]);
            end
        end
    endtask

    initial begin
        ld_req  = 1'b0;
        ld_addr = '0;
        st_req  = 1'b0;
        st_addr = '0;
        st_data = '0;
        st_mask = '0;
        seed    = 32'hed4f_32e0;
        for (int i = 0; i < 1024; i++) begin
            shadow[10'(i)] = 32'(i << 2) ^ 32'h5a5a_0000;
        end
        @(negedge clk);
        while (rst) @(negedge clk);
        cold_load_miss();
        store_then_load();
        dirty_eviction();
        lru_order();
        random_mix();
        repeat (4) @(negedge clk);
        $display("%0d check errors, %0d assertion failures", errors, UUT.props.fail_cnt);
        if (errors == 0 && UUT.props.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/cache_cfg_pkg.sv
design/mem_bus_pkg.sv
design/dcache_way.sv
design/dcache_lru.sv
design/dcache_refill.sv
design/dcache_evict.sv
design/dcache_ctrl.sv
design/dcache_top.sv
dv/clk_gen.sv
dv/mem_model.sv
dv/dcache_props.sv
dv/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --assert --top-module dcache_tb -f verilog.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" sim.log; then
    exit 0
fi
echo "simulation did not pass"
exit 1
